// ==== Makefile ====
# Verilator build for the ALU testbench

TOP := alu_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) \
		--Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)

// ==== design/alu_arith.sv ====
// ALU add and subtract family
`timescale 1ns/100ps

module alu_arith
    import alu_op_pkg::*;
(
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_op_e               op,
    input  logic                  carry_in,
    output logic [data_width-1:0] sum,
    output logic                  carry,
    output logic                  overflow
);

    // left and right operands of the shared 9-bit adder
    logic [data_width-1:0] left;
    logic [data_width-1:0] right;
    logic                  is_sub;
    // only the three carry-consuming ops let the stored carry in
    logic                  use_cin;
    logic                  in_family;
    // negate reuses the subtractor but reports no carry or overflow
    logic                  is_negate;
    logic [data_width:0]   full;
    logic [data_width:0]   cin_ext;
    logic                  l_sign;
    logic                  r_sign;
    logic                  s_sign;
    logic                  ov_add;
    logic                  ov_sub;

    // decode the op into operands and direction
    always_comb begin
        left      = a;
        right     = b;
        is_sub    = 1'b0;
        use_cin   = 1'b0;
        in_family = 1'b1;
        is_negate = 1'b0;
        case (op)
            op_neg_a: begin
                left      = '0;
                right     = a;
                is_sub    = 1'b1;
                is_negate = 1'b1;
            end
            op_neg_b: begin
                left      = '0;
                is_sub    = 1'b1;
                is_negate = 1'b1;
            end
            // increment and decrement set carry but never take it in
            op_inc_a: right = data_width'(1);
            op_inc_b: begin
                left  = b;
                right = data_width'(1);
            end
            op_dec_a: begin
                right  = data_width'(1);
                is_sub = 1'b1;
            end
            op_dec_b: begin
                left   = b;
                right  = data_width'(1);
                is_sub = 1'b1;
            end
            op_a_add_b: ;
            op_a_sub_b, op_a_sub_b_smag: is_sub = 1'b1;
            op_b_sub_a: begin
                left   = b;
                right  = a;
                is_sub = 1'b1;
            end
            op_a_add_b_c: use_cin = 1'b1;
            op_a_sub_b_c: begin
                is_sub  = 1'b1;
                use_cin = 1'b1;
            end
            op_b_sub_a_c: begin
                left    = b;
                right   = a;
                is_sub  = 1'b1;
                use_cin = 1'b1;
            end
            default: in_family = 1'b0;
        endcase
    end

    // with carry_in clear the carry forms fall back to the plain ones
    assign cin_ext = {{data_width{1'b0}}, use_cin & carry_in};

    // bit 8 is the carry on add and the borrow on subtract
    assign full = is_sub ? {1'b0, left} - {1'b0, right} - cin_ext
                         : {1'b0, left} + {1'b0, right} + cin_ext;

    assign l_sign = left[data_width-1];
    assign r_sign = right[data_width-1];
    assign s_sign = full[data_width-1];

    // add overflows when like signs give a result of the other sign
    assign ov_add = (l_sign == r_sign) && (s_sign != l_sign);
    // subtract overflows when unlike signs give a result unlike the left operand
    assign ov_sub = (l_sign != r_sign) && (s_sign != l_sign);

    assign sum      = in_family ? full[data_width-1:0] : '0;
    assign carry    = in_family && !is_negate && full[data_width];
    assign overflow = in_family && !is_negate && (is_sub ? ov_sub : ov_add);

endmodule

// ==== design/alu_core.sv ====
// ALU operation select and flag logic
`timescale 1ns/100ps

module alu_core
    import alu_op_pkg::*;
    import alu_flag_pkg::*;
(
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_op_e               alu_op,
    input  logic                  carry_in,
    output logic [data_width-1:0] result,
    output logic [flag_count-1:0] flags_next
);

    logic [data_width-1:0] arith_sum;
    logic                  arith_carry;
    logic                  arith_ov;
    logic [data_width-1:0] shift_out;
    logic                  shift_carry;
    logic                  carry_sel;
    logic                  ov_sel;
    // shifts, rotates and logic ops report overflow as a change of sign against a
    logic                  sign_ov;
    logic                  signed_cmp;

    alu_arith i_arith (
        .a        (a),
        .b        (b),
        .op       (alu_op),
        .carry_in (carry_in),
        .sum      (arith_sum),
        .carry    (arith_carry),
        .overflow (arith_ov)
    );

    alu_shift i_shift (
        .a        (a),
        .b        (b),
        .op       (alu_op),
        .carry_in (carry_in),
        .shifted  (shift_out),
        .carry    (shift_carry)
    );

    // steer by opcode class, zero and unused codes keep the cleared defaults
    always_comb begin
        result    = '0;
        carry_sel = 1'b0;
        ov_sel    = 1'b0;
        sign_ov   = 1'b0;
        case (alu_op)
            // pass leaves carry clear
            op_pass_a: result = a;
            op_pass_b: result = b;
            op_neg_a, op_neg_b, op_inc_a, op_inc_b, op_dec_a, op_dec_b,
            op_a_add_b, op_a_sub_b, op_b_sub_a, op_a_sub_b_smag,
            op_a_add_b_c, op_a_sub_b_c, op_b_sub_a_c: begin
                result    = arith_sum;
                carry_sel = arith_carry;
                ov_sel    = arith_ov;
            end
            op_lsl, op_lsr, op_asr, op_rol, op_ror: begin
                result    = shift_out;
                carry_sel = shift_carry;
                sign_ov   = 1'b1;
            end
            // logic ops never produce a carry
            op_and: begin
                result  = a & b;
                sign_ov = 1'b1;
            end
            op_or: begin
                result  = a | b;
                sign_ov = 1'b1;
            end
            op_xor: begin
                result  = a ^ b;
                sign_ov = 1'b1;
            end
            op_not_a: begin
                result  = ~a;
                sign_ov = 1'b1;
            end
            op_not_b: begin
                result  = ~b;
                sign_ov = 1'b1;
            end
            default: ;
        endcase
    end

    // only the signed-magnitude subtract compares the operands as signed
    assign signed_cmp = (alu_op == op_a_sub_b_smag);

    always_comb begin
        flags_next          = '0;
        flags_next[flag_c]  = carry_sel;
        flags_next[flag_z]  = (result == '0);
        flags_next[flag_n]  = result[data_width-1];
        flags_next[flag_o]  = sign_ov ? (result[data_width-1] != a[data_width-1]) : ov_sel;
        flags_next[flag_gt] = signed_cmp ? ($signed(a) > $signed(b)) : (a > b);
        flags_next[flag_lt] = signed_cmp ? ($signed(a) < $signed(b)) : (a < b);
        flags_next[flag_eq] = (a == b);
        flags_next[flag_ne] = (a != b);
    end

endmodule

// ==== design/alu_flag_pkg.sv ====
// ALU status flag layout
package alu_flag_pkg;

    // number of bits in the status vector
    localparam int flag_count = 8;

    // bit positions inside the flag vector, all flags active high
    // carry, also the borrow on subtracts
    localparam int flag_c  = 0;
    // result is zero
    localparam int flag_z  = 1;
    // result sign bit
    localparam int flag_n  = 2;
    // two's complement overflow
    localparam int flag_o  = 3;
    // a above b, signed only under the signed-magnitude subtract
    localparam int flag_gt = 4;
    localparam int flag_lt = 5;
    // operand equality, always on the raw inputs
    localparam int flag_eq = 6;
    localparam int flag_ne = 7;

endpackage

// ==== design/alu_op_pkg.sv ====
// ALU opcodes and widths
package alu_op_pkg;

    // operand and result width, fixed at one byte
    localparam int data_width = 8;

    // opcode map keeps the original numeric codes so existing programs still decode
    // codes 16 to 19, 30 and 31 have no operation and decode as unused
    typedef enum logic [4:0] {
        op_zero         = 5'd0,
        op_pass_a       = 5'd1,
        op_pass_b       = 5'd2,
        op_neg_a        = 5'd3,
        op_neg_b        = 5'd4,
        op_inc_a        = 5'd5,
        op_inc_b        = 5'd6,
        op_dec_a        = 5'd7,
        op_dec_b        = 5'd8,
        op_a_add_b      = 5'd9,
        op_a_sub_b      = 5'd10,
        op_b_sub_a      = 5'd11,
        // same difference as op_a_sub_b, but gt/lt compare signed
        op_a_sub_b_smag = 5'd12,
        // carry-consuming forms, they fold to 9..11 when carry_in is clear
        op_a_add_b_c    = 5'd13,
        op_a_sub_b_c    = 5'd14,
        op_b_sub_a_c    = 5'd15,
        op_lsl          = 5'd20,
        op_lsr          = 5'd21,
        op_asr          = 5'd22,
        // rotates run through carry as a 9-bit ring
        op_rol          = 5'd23,
        op_ror          = 5'd24,
        op_and          = 5'd25,
        op_or           = 5'd26,
        op_xor          = 5'd27,
        op_not_a        = 5'd28,
        op_not_b        = 5'd29
    } alu_op_e;

endpackage

// ==== design/alu_shift.sv ====
// ALU shifts and rotates through carry
`timescale 1ns/100ps

module alu_shift
    import alu_op_pkg::*;
(
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_op_e               op,
    input  logic                  carry_in,
    output logic [data_width-1:0] shifted,
    output logic                  carry
);

    // a with one extra bit beside it to catch the last bit shifted out
    logic [data_width:0]     lsl_ext;
    logic [data_width:0]     lsr_ext;
    logic [data_width:0]     asr_ext;
    // carry and a together form the 9-bit rotate ring
    logic [data_width:0]     ring;
    logic [3:0]              rot_count;
    // the ring laid twice side by side turns a rotate into a plain shift
    logic [2*data_width+1:0] rol_dbl;
    logic [2*data_width+1:0] ror_dbl;

    // left shift, the extra bit sits above a and ends up as the carry
    assign lsl_ext = {1'b0, a} << b;

    // right shifts put the extra bit below a, so carry is bit 0
    assign lsr_ext = {a, 1'b0} >> b;
    // large counts fill with the sign, which then also lands in the carry
    assign asr_ext = $signed({a, 1'b0}) >>> b;

    assign ring      = {carry_in, a};
    // a ring of nine turns a full circle every nine places
    assign rot_count = 4'(b % (data_width + 1));

    assign rol_dbl = {ring, ring} << rot_count;
    assign ror_dbl = {ring, ring} >> rot_count;

    always_comb begin
        shifted = '0;
        carry   = 1'b0;
        case (op)
            op_lsl: begin
                shifted = lsl_ext[data_width-1:0];
                carry   = lsl_ext[data_width];
            end
            op_lsr: begin
                shifted = lsr_ext[data_width:1];
                carry   = lsr_ext[0];
            end
            op_asr: begin
                shifted = asr_ext[data_width:1];
                carry   = asr_ext[0];
            end
            // upper half of the left-shifted pair is the turned ring, carry on top
            op_rol: begin
                shifted = rol_dbl[2*data_width:data_width+1];
                carry   = rol_dbl[2*data_width+1];
            end
            // lower half of the right-shifted pair is the turned ring
            op_ror: begin
                shifted = ror_dbl[data_width-1:0];
                carry   = ror_dbl[data_width];
            end
            default: ;
        endcase
    end

endmodule

// ==== design/alu_status_reg.sv ====
// ALU status register
`timescale 1ns/100ps

module alu_status_reg
    import alu_flag_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flags_we,
    input  logic [flag_count-1:0] flags_next,
    output logic [flag_count-1:0] flags,
    output logic                  carry_in
);

    // flags load only on the strobe and hold otherwise
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (flags_we) begin
            flags <= flags_next;
        end
    end

    // stored carry goes back to the core as its carry-in
    assign carry_in = flags[flag_c];

    // the core must always report exactly one of eq and ne
    a_eq_ne_complement: assert property (
        @(posedge clk) disable iff (!arst_n)
        flags_next[flag_eq] != flags_next[flag_ne]
    );

    // a compare can never be both above and below
    a_gt_lt_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(flags_next[flag_gt] && flags_next[flag_lt])
    );

    // a zero result has no sign bit set
    a_z_excludes_n: assert property (
        @(posedge clk) disable iff (!arst_n)
        flags_next[flag_z] |-> !flags_next[flag_n]
    );

    // reset must leave the register clear at the next edge
    a_flags_clear_after_reset: assert property (
        @(posedge clk) !arst_n |=> (flags == '0)
    );

endmodule

// ==== design/alu_top.sv ====
// ALU top level
`timescale 1ns/100ps

module alu_top
    import alu_op_pkg::*;
    import alu_flag_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_op_e               alu_op,
    input  logic                  flags_we,
    output logic [data_width-1:0] result,
    output logic [flag_count-1:0] flags
);

    // combinational flags from the core, waiting for the strobe
    logic [flag_count-1:0] flags_next;
    // registered carry fed back into the core
    logic                  carry_in;

    alu_core i_core (
        .a          (a),
        .b          (b),
        .alu_op     (alu_op),
        .carry_in   (carry_in),
        .result     (result),
        .flags_next (flags_next)
    );

    alu_status_reg i_status (
        .clk        (clk),
        .arst_n     (arst_n),
        .flags_we   (flags_we),
        .flags_next (flags_next),
        .flags      (flags),
        .carry_in   (carry_in)
    );

endmodule

// ==== dv/alu_ref.svh ====
// ALU reference model and LFSR
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

// one step of a 32-bit Galois LFSR, taps for x^32+x^22+x^2+x+1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic lsb;
    lsb = state[0];
    state = state >> 1;
    if (lsb) begin
        state = state ^ 32'h8020_0003;
    end
    return state;
endfunction

// expected result and flag vector for one operation with a given stored carry
function automatic void alu_model(input logic [7:0] a, input logic [7:0] b,
                                  input logic [4:0] op, input logic cin,
                                  output logic [7:0] res, output logic [7:0] flg);
    logic [8:0] wide;
    logic [7:0] l;
    logic [7:0] r;
    logic       ci;
    logic       sub;
    logic       arith;
    logic       c;
    logic       o;
    logic       sign_ov;
    int         n;
    res = '0;
    c = 1'b0;
    o = 1'b0;
    sign_ov = 1'b0;
    arith = 1'b0;
    sub = 1'b0;
    ci = 1'b0;
    l = a;
    r = b;
    // shift counts of nine or more all behave like nine
    n = (b > 8'd9) ? 9 : int'(b);
    case (op)
        op_pass_a: res = a;
        op_pass_b: res = b;
        // negate never reports carry or overflow
        op_neg_a: res = 8'(9'd0 - {1'b0, a});
        op_neg_b: res = 8'(9'd0 - {1'b0, b});
        op_inc_a: {arith, r} = {1'b1, 8'd1};
        op_inc_b: {arith, l, r} = {1'b1, b, 8'd1};
        op_dec_a: {arith, sub, r} = {2'b11, 8'd1};
        op_dec_b: {arith, sub, l, r} = {2'b11, b, 8'd1};
        op_a_add_b: arith = 1'b1;
        op_a_sub_b, op_a_sub_b_smag: {arith, sub} = 2'b11;
        op_b_sub_a: {arith, sub, l, r} = {2'b11, b, a};
        op_a_add_b_c: {arith, ci} = {1'b1, cin};
        op_a_sub_b_c: {arith, sub, ci} = {2'b11, cin};
        op_b_sub_a_c: {arith, sub, ci, l, r} = {2'b11, cin, b, a};
        op_lsl: begin
            wide = {1'b0, a};
            repeat (n) wide = wide << 1;
            {c, res} = wide;
            sign_ov = 1'b1;
        end
        op_lsr: begin
            wide = {a, 1'b0};
            repeat (n) wide = wide >> 1;
            {res, c} = wide;
            sign_ov = 1'b1;
        end
        op_asr: begin
            wide = {a, 1'b0};
            repeat (n) wide = {wide[8], wide[8:1]};
            {res, c} = wide;
            sign_ov = 1'b1;
        end
        // the carry sits on top of a in the nine-bit ring
        op_rol: begin
            wide = {cin, a};
            repeat (int'(b) % 9) wide = {wide[7:0], wide[8]};
            {c, res} = wide;
            sign_ov = 1'b1;
        end
        op_ror: begin
            wide = {cin, a};
            repeat (int'(b) % 9) wide = {wide[0], wide[8:1]};
            {c, res} = wide;
            sign_ov = 1'b1;
        end
        op_and: {sign_ov, res} = {1'b1, a & b};
        op_or: {sign_ov, res} = {1'b1, a | b};
        op_xor: {sign_ov, res} = {1'b1, a ^ b};
        op_not_a: {sign_ov, res} = {1'b1, ~a};
        op_not_b: {sign_ov, res} = {1'b1, ~b};
        default: ;
    endcase
    if (arith) begin
        wide = sub ? ({1'b0, l} - {1'b0, r} - {8'd0, ci}) : ({1'b0, l} + {1'b0, r} + {8'd0, ci});
        {c, res} = wide;
        if (sub) o = (l[7] != r[7]) && (res[7] != l[7]);
        else o = (l[7] == r[7]) && (res[7] != l[7]);
    end
    if (sign_ov) o = (res[7] != a[7]);
    flg = '0;
    flg[flag_c] = c;
    flg[flag_z] = (res == 8'd0);
    flg[flag_n] = res[7];
    flg[flag_o] = o;
    if (op == op_a_sub_b_smag) begin
        flg[flag_gt] = $signed(a) > $signed(b);
        flg[flag_lt] = $signed(a) < $signed(b);
    end else begin
        flg[flag_gt] = a > b;
        flg[flag_lt] = a < b;
    end
    flg[flag_eq] = (a == b);
    flg[flag_ne] = (a != b);
endfunction

`endif

// ==== dv/alu_tb.sv ====
// ALU testbench
`timescale 1ns/100ps

module alu_tb
    import alu_op_pkg::*;
    import alu_flag_pkg::*;
;

    `include "alu_ref.svh"

    logic                  clk;
    logic                  arst_n;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    alu_op_e               alu_op;
    logic                  flags_we;
    logic [data_width-1:0] result;
    logic [flag_count-1:0] flags;

    string       test_name;
    logic [31:0] lfsr_state;
    // model of the status register as tracked from the strobe
    logic        model_carry;
    logic [7:0]  exp_flags;
    logic [7:0]  exp_res;
    logic [7:0]  next_flags;
    logic        we_seen;
    int          wait_cycles;

    alu_top i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (a),
        .b        (b),
        .alu_op   (alu_op),
        .flags_we (flags_we),
        .result   (result),
        .flags    (flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // take n bits from the LFSR with one step per bit
    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // one operation per cycle is driven just after the edge and sampled late
    task automatic apply_op(input logic [7:0] av, input logic [7:0] bv, input logic [4:0] op,
                            input logic we, output logic [7:0] res);
        @(posedge clk);
        #2;
        a = av;
        b = bv;
        alu_op = alu_op_e'(op);
        flags_we = we;
        #30;
        res = result;
    endtask

    task automatic set_carry(input logic c);
        logic [7:0] unused;
        apply_op(c ? 8'hff : 8'h00, 8'h01, op_a_add_b, 1'b1, unused);
    endtask

    // adds or subtracts two 16-bit values a byte at a time through the stored carry
    task automatic chain16(input logic [15:0] x, input logic [15:0] y, input logic [4:0] op_lo,
                           input logic [4:0] op_hi, input logic [15:0] expect16);
        logic [7:0] lo;
        logic [7:0] hi;
        apply_op(x[7:0], y[7:0], op_lo, 1'b1, lo);
        apply_op(x[15:8], y[15:8], op_hi, 1'b1, hi);
        assert ({hi, lo} == expect16) else
            fail_run($sformatf("** Error %s: 16-bit expected %h actual %h",
                               test_name, expect16, {hi, lo}));
    endtask

    // result is checked just before each edge and flags just after it
    initial begin
        model_carry = 1'b0;
        exp_flags = '0;
        wait_cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > 50) fail_run("reset was never released");
        end
        @(posedge clk);
        #1;
        forever begin
            #36;
            alu_model(a, b, alu_op, model_carry, exp_res, next_flags);
            we_seen = flags_we;
            assert (result === exp_res) else
                fail_run($sformatf("** Error %s: result expected %h actual %h",
                                   test_name, exp_res, result));
            #4;
            if (we_seen) begin
                exp_flags = next_flags;
                model_carry = next_flags[flag_c];
            end
            assert (flags === exp_flags) else
                fail_run($sformatf("** Error %s: flags expected %b actual %b",
                                   test_name, exp_flags, flags));
        end
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  res;
        logic [7:0]  bvals[6];
        logic [4:0]  shift_ops[5];
        logic [4:0]  misc_ops[13];
        clk_setup: begin
            a = '0;
            b = '0;
            alu_op = op_zero;
            flags_we = 1'b0;
            arst_n = 1'b0;
            lfsr_state = 32'hb504;
            test_name = "reset";
        end
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        // a cycle without the strobe must leave the cleared flags alone
        apply_op(8'h80, 8'h80, op_a_add_b, 1'b0, res);
        apply_op(8'h00, 8'h00, op_zero, 1'b0, res);

        test_name = "carry_chain";
        chain16(16'h12ff, 16'h34f1, op_a_add_b, op_a_add_b_c, 16'h12ff + 16'h34f1);
        chain16(16'hffff, 16'h0001, op_a_add_b, op_a_add_b_c, 16'h0000);
        chain16(16'h1200, 16'h0301, op_a_sub_b, op_a_sub_b_c, 16'h1200 - 16'h0301);
        chain16(16'h0001, 16'h0002, op_a_sub_b, op_a_sub_b_c, 16'hffff);
        chain16(16'h0310, 16'h5005, op_b_sub_a, op_b_sub_a_c, 16'h5005 - 16'h0310);

        test_name = "overflow_sign";
        apply_op(8'h7f, 8'h01, op_a_add_b, 1'b1, res);
        apply_op(8'h80, 8'h01, op_a_sub_b, 1'b1, res);
        apply_op(8'h00, 8'h00, op_a_sub_b, 1'b1, res);
        apply_op(8'h80, 8'h80, op_a_add_b, 1'b1, res);
        apply_op(8'h7f, 8'h00, op_inc_a, 1'b1, res);
        apply_op(8'h00, 8'hff, op_inc_b, 1'b1, res);
        apply_op(8'h80, 8'h00, op_dec_a, 1'b1, res);
        apply_op(8'h00, 8'h00, op_dec_b, 1'b1, res);
        apply_op(8'h80, 8'h00, op_neg_a, 1'b1, res);
        apply_op(8'h00, 8'h01, op_neg_b, 1'b1, res);
        apply_op(8'h01, 8'h80, op_b_sub_a, 1'b1, res);

        test_name = "shift_rotate";
        shift_ops = '{op_lsl, op_lsr, op_asr, op_rol, op_ror};
        foreach (shift_ops[i]) begin
            for (int c = 0; c < 2; c++) begin
                take_bits(16, r);
                bvals = '{8'd0, 8'd8, 8'd9, 8'd200, r[7:0], {5'd0, r[10:8]}};
                foreach (bvals[j]) begin
                    set_carry(c[0]);
                    take_bits(8, r);
                    apply_op(r[7:0], bvals[j], shift_ops[i], 1'b1, res);
                end
            end
        end

        test_name = "logic_compare";
        misc_ops = '{op_zero, op_pass_a, op_pass_b, op_and, op_or, op_xor, op_not_a,
                     op_not_b, op_a_sub_b_smag, op_a_sub_b, 5'd16, 5'd30, 5'd31};
        foreach (misc_ops[i]) begin
            for (int k = 0; k < 12; k++) begin
                take_bits(16, r);
                if (k == 0) r[7:0] = r[15:8];
                apply_op(r[15:8], r[7:0], misc_ops[i], 1'b1, res);
            end
        end

        test_name = "random_sweep";
        for (int k = 0; k < 2000; k++) begin
            take_bits(22, r);
            apply_op(r[21:14], r[13:6], r[5:1], r[0], res);
        end

        @(posedge clk);
        #5;
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== files.f ====
design/alu_op_pkg.sv
design/alu_flag_pkg.sv
design/alu_arith.sv
design/alu_shift.sv
design/alu_core.sv
design/alu_status_reg.sv
design/alu_top.sv
+incdir+dv
dv/alu_tb.sv
